//--- Makefile
# Verilator build and run of the instruction cache control testbench

SRCS := $(shell grep -v '^+' verilog.f) icc_macros.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_icache_ctrl: verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module tb_icache_ctrl \
		-o Vtb_icache_ctrl

sim.log: obj_dir/Vtb_icache_ctrl
	./obj_dir/Vtb_icache_ctrl > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- icache_ctrl_unit.sv
// Instruction cache control unit: register slave, target sequencer and statistics
`timescale 1ns/10ps
`default_nettype none

`include "icc_macros.svh"

module icache_ctrl_unit (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    // Peripheral slave port
    input  logic                            speriph_req_i,
    input  logic [31:0]                     speriph_addr_i,
    input  logic                            speriph_wen_i,
    input  logic [31:0]                     speriph_wdata_i,
    input  logic [`ICC_ID_W-1:0]            speriph_id_i,
    output logic                            speriph_gnt_o,
    output logic                            speriph_r_valid_o,
    output logic [`ICC_ID_W-1:0]            speriph_r_id_o,
    output logic [31:0]                     speriph_r_rdata_o,

    // L1 caches
    output logic [`ICC_NB_CORES-1:0]        l1_bypass_req_o,
    input  logic [`ICC_NB_CORES-1:0]        l1_bypass_ack_i,
    output logic [`ICC_NB_CORES-1:0]        l1_flush_req_o,
    input  logic [`ICC_NB_CORES-1:0]        l1_flush_ack_i,

    // L2 banks
    output logic [`ICC_NB_BANKS-1:0]        l2_enable_req_o,
    input  logic [`ICC_NB_BANKS-1:0]        l2_enable_ack_i,
    output logic [`ICC_NB_BANKS-1:0]        l2_disable_req_o,
    input  logic [`ICC_NB_BANKS-1:0]        l2_disable_ack_i,
    output logic [`ICC_NB_BANKS-1:0]        l2_flush_req_o,
    input  logic [`ICC_NB_BANKS-1:0]        l2_flush_ack_i,

    // Performance counters
    input  logic [`ICC_NB_CORES-1:0][31:0]  l1_hit_count_i,
    input  logic [`ICC_NB_CORES-1:0][31:0]  l1_trans_count_i,
    input  logic [`ICC_NB_CORES-1:0][31:0]  l1_miss_count_i,
    output logic [`ICC_NB_CORES-1:0]        l1_clear_regs_o,
    output logic [`ICC_NB_CORES-1:0]        l1_enable_regs_o,
    input  logic [`ICC_NB_BANKS-1:0][31:0]  l2_hit_count_i,
    input  logic [`ICC_NB_BANKS-1:0][31:0]  l2_trans_count_i,
    input  logic [`ICC_NB_BANKS-1:0][31:0]  l2_miss_count_i,
    output logic [`ICC_NB_BANKS-1:0]        l2_clear_regs_o,
    output logic [`ICC_NB_BANKS-1:0]        l2_enable_regs_o
);

    icc_seq_if  seq_if ();
    icc_stat_if stat_if ();

    icc_reg_slave reg_slave_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (speriph_req_i),
        .addr_i    (speriph_addr_i),
        .wen_i     (speriph_wen_i),
        .wdata_i   (speriph_wdata_i),
        .id_i      (speriph_id_i),
        .gnt_o     (speriph_gnt_o),
        .r_valid_o (speriph_r_valid_o),
        .r_id_o    (speriph_r_id_o),
        .r_rdata_o (speriph_r_rdata_o),
        .seq       (seq_if.master),
        .stat      (stat_if.master)
    );

    icc_target_seq target_seq_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .seq              (seq_if.target),
        .l1_bypass_req_o  (l1_bypass_req_o),
        .l1_bypass_ack_i  (l1_bypass_ack_i),
        .l1_flush_req_o   (l1_flush_req_o),
        .l1_flush_ack_i   (l1_flush_ack_i),
        .l2_enable_req_o  (l2_enable_req_o),
        .l2_enable_ack_i  (l2_enable_ack_i),
        .l2_disable_req_o (l2_disable_req_o),
        .l2_disable_ack_i (l2_disable_ack_i),
        .l2_flush_req_o   (l2_flush_req_o),
        .l2_flush_ack_i   (l2_flush_ack_i)
    );

    icc_stat_unit stat_unit_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .stat             (stat_if.target),
        .l1_hit_count_i   (l1_hit_count_i),
        .l1_trans_count_i (l1_trans_count_i),
        .l1_miss_count_i  (l1_miss_count_i),
        .l2_hit_count_i   (l2_hit_count_i),
        .l2_trans_count_i (l2_trans_count_i),
        .l2_miss_count_i  (l2_miss_count_i),
        .l1_clear_regs_o  (l1_clear_regs_o),
        .l1_enable_regs_o (l1_enable_regs_o),
        .l2_clear_regs_o  (l2_clear_regs_o),
        .l2_enable_regs_o (l2_enable_regs_o)
    );

endmodule

`default_nettype wire

//--- icc_ifs.sv
// Internal links from the register slave to the target sequencer and the stat unit
`timescale 1ns/10ps
`default_nettype none

`include "icc_macros.svh"

interface icc_seq_if
    import icc_pkg::*;
();
    logic             start;        // One-cycle strobe, only while not busy
    icc_seq_op_e      op;
    logic             value;        // Written data bit 0
    logic             busy;
    logic             done;         // Cycle of the final ack
    icc_target_word_u enable_word;
    icc_target_word_u flush_word;

    modport master (
        output start,
        output op,
        output value,
        input  busy,
        input  done,
        input  enable_word,
        input  flush_word
    );

    modport target (
        input  start,
        input  op,
        input  value,
        output busy,
        output done,
        output enable_word,
        output flush_word
    );
endinterface

interface icc_stat_if
    import icc_pkg::*;
();
    logic                               clear_stb;
    logic                               enable_stb;
    logic                               value;
    icc_target_word_u                   cnt_enable_word;
    logic [`ICC_NB_SUMS-1:0][31:0]      global_sum;    // Registered, wrapping

    modport master (
        output clear_stb,
        output enable_stb,
        output value,
        input  cnt_enable_word,
        input  global_sum
    );

    modport target (
        input  clear_stb,
        input  enable_stb,
        input  value,
        output cnt_enable_word,
        output global_sum
    );
endinterface

`default_nettype wire

//--- icc_macros.svh
// Instruction cache control configuration: target counts, register map and counter indices
`ifndef ICC_MACROS_SVH
`define ICC_MACROS_SVH

// Target counts and bus id width
`define ICC_NB_CORES 8
`define ICC_NB_BANKS 4
`define ICC_ID_W     5

// Register byte offsets
`define ICC_REG_ENABLE      8'h00
`define ICC_REG_FLUSH       8'h04
`define ICC_REG_FLUSH_L1    8'h08
`define ICC_REG_CLEAR_CNTS  8'h10
`define ICC_REG_ENABLE_CNTS 8'h14

// Global counter sums, word index of the first one is 0x30 >> 2
`define ICC_CNT_BASE     12
`define ICC_NB_SUMS      6
`define ICC_SUM_L1_HIT   0
`define ICC_SUM_L1_TRANS 1
`define ICC_SUM_L1_MISS  2
`define ICC_SUM_L2_HIT   3
`define ICC_SUM_L2_TRANS 4
`define ICC_SUM_L2_MISS  5

// Returned for reads outside the map
`define ICC_BAD_ADDR_DATA 32'hDEAD_CA5E

`endif

//--- icc_pkg.sv
// Shared types of the instruction cache control block
`default_nettype none

`include "icc_macros.svh"

package icc_pkg;

    // One bit per target, L1 cores in the low bits
    typedef struct packed {
        logic [31-`ICC_NB_BANKS-`ICC_NB_CORES:0] pad;  // Always zero
        logic [`ICC_NB_BANKS-1:0]                l2;
        logic [`ICC_NB_CORES-1:0]                l1;
    } icc_target_bits_t;

    // Register word as read back, or as per-target masks
    typedef union packed {
        logic [31:0]      word;
        icc_target_bits_t bits;
    } icc_target_word_u;

    // Operations handed to the target sequencer
    typedef enum logic [1:0] {
        OP_ENABLE    = 2'd0,
        OP_DISABLE   = 2'd1,
        OP_FLUSH_ALL = 2'd2,
        OP_FLUSH_L1  = 2'd3
    } icc_seq_op_e;

endpackage

`default_nettype wire

//--- icc_reg_slave.sv
// Peripheral register slave: decodes accesses, dispatches writes and returns responses
`timescale 1ns/10ps
`default_nettype none

`include "icc_macros.svh"

module icc_reg_slave
    import icc_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  req_i,
    input  logic [31:0]           addr_i,
    input  logic                  wen_i,     // 1 means read
    input  logic [31:0]           wdata_i,
    input  logic [`ICC_ID_W-1:0]  id_i,
    output logic                  gnt_o,
    output logic                  r_valid_o,
    output logic [`ICC_ID_W-1:0]  r_id_o,
    output logic [31:0]           r_rdata_o,

    icc_seq_if.master             seq,
    icc_stat_if.master            stat
);

    logic        accept;
    logic        is_read;
    logic [7:0]  offset;
    logic [5:0]  word_idx;
    logic [2:0]  cnt_sel;
    logic        cnt_hit;
    logic        seq_pend_q;
    logic        r_valid_d;
    logic [31:0] rdata_d;

    assign gnt_o    = ~seq.busy;     // Only the sequencer stalls the bus
    assign accept   = req_i & gnt_o;
    assign is_read  = wen_i;
    assign offset   = addr_i[7:0];
    assign word_idx = addr_i[7:2];

    // Counter window
    assign cnt_hit = (word_idx >= 6'(`ICC_CNT_BASE)) &&
                     (word_idx <  6'(`ICC_CNT_BASE + `ICC_NB_SUMS));
    assign cnt_sel = 3'(word_idx - 6'(`ICC_CNT_BASE));

    assign seq.value  = wdata_i[0];
    assign stat.value = wdata_i[0];

    // Write dispatch
    always_comb begin
        seq.start       = 1'b0;
        seq.op          = OP_ENABLE;
        stat.clear_stb  = 1'b0;
        stat.enable_stb = 1'b0;
        if (accept && !is_read) begin
            case (offset)
                `ICC_REG_ENABLE: begin
                    seq.start = 1'b1;
                    seq.op    = wdata_i[0] ? OP_ENABLE : OP_DISABLE;
                end
                `ICC_REG_FLUSH: begin
                    seq.start = 1'b1;
                    seq.op    = OP_FLUSH_ALL;
                end
                `ICC_REG_FLUSH_L1: begin
                    seq.start = 1'b1;
                    seq.op    = OP_FLUSH_L1;
                end
                `ICC_REG_CLEAR_CNTS:  stat.clear_stb  = 1'b1;
                `ICC_REG_ENABLE_CNTS: stat.enable_stb = 1'b1;
                default: ;   // Unmapped, answered right away
            endcase
        end
    end

    // Read mux
    always_comb begin
        rdata_d = `ICC_BAD_ADDR_DATA;
        case (offset)
            `ICC_REG_ENABLE:      rdata_d = seq.enable_word.word;
            `ICC_REG_FLUSH:       rdata_d = seq.flush_word.word;
            `ICC_REG_ENABLE_CNTS: rdata_d = stat.cnt_enable_word.word;
            default: begin
                if (cnt_hit) begin
                    rdata_d = stat.global_sum[cnt_sel];
                end
            end
        endcase
    end

    // Sequencer writes answer the cycle after done
    assign r_valid_d = (accept & ~seq.start) | (seq_pend_q & seq.done);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            r_valid_o  <= 1'b0;
            seq_pend_q <= 1'b0;
        end else begin
            r_valid_o <= r_valid_d;
            if (seq.start) begin
                seq_pend_q <= 1'b1;
            end else if (seq.done) begin
                seq_pend_q <= 1'b0;
            end
        end
    end

    // Id and data sampled at acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            r_id_o    <= id_i;
            r_rdata_o <= rdata_d;
        end
    end

endmodule

`default_nettype wire

//--- icc_stat_unit.sv
// Statistics unit: counter enables, clear pulse and global counter sums
`timescale 1ns/10ps
`default_nettype none

`include "icc_macros.svh"

module icc_stat_unit
    import icc_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_ni,

    icc_stat_if.target                      stat,

    input  logic [`ICC_NB_CORES-1:0][31:0]  l1_hit_count_i,
    input  logic [`ICC_NB_CORES-1:0][31:0]  l1_trans_count_i,
    input  logic [`ICC_NB_CORES-1:0][31:0]  l1_miss_count_i,
    input  logic [`ICC_NB_BANKS-1:0][31:0]  l2_hit_count_i,
    input  logic [`ICC_NB_BANKS-1:0][31:0]  l2_trans_count_i,
    input  logic [`ICC_NB_BANKS-1:0][31:0]  l2_miss_count_i,

    output logic [`ICC_NB_CORES-1:0]        l1_clear_regs_o,
    output logic [`ICC_NB_CORES-1:0]        l1_enable_regs_o,
    output logic [`ICC_NB_BANKS-1:0]        l2_clear_regs_o,
    output logic [`ICC_NB_BANKS-1:0]        l2_enable_regs_o
);

    icc_target_word_u               cnt_en_q;
    logic [`ICC_NB_SUMS-1:0][31:0]  sum_d;
    logic [`ICC_NB_SUMS-1:0][31:0]  sum_q;

    assign l1_enable_regs_o     = cnt_en_q.bits.l1;
    assign l2_enable_regs_o     = cnt_en_q.bits.l2;
    assign stat.cnt_enable_word = cnt_en_q;
    assign stat.global_sum      = sum_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_en_q        <= '0;
            l1_clear_regs_o <= '0;
            l2_clear_regs_o <= '0;
        end else begin
            if (stat.enable_stb) begin
                cnt_en_q.bits.l1 <= {`ICC_NB_CORES{stat.value}};
                cnt_en_q.bits.l2 <= {`ICC_NB_BANKS{stat.value}};
            end
            // One-cycle clear, bits follow written bit 0
            l1_clear_regs_o <= {`ICC_NB_CORES{stat.clear_stb & stat.value}};
            l2_clear_regs_o <= {`ICC_NB_BANKS{stat.clear_stb & stat.value}};
        end
    end

    // Sums wrap at 32 bits
    always_comb begin
        sum_d = '0;
        for (int c = 0; c < `ICC_NB_CORES; c++) begin
            sum_d[`ICC_SUM_L1_HIT]   = sum_d[`ICC_SUM_L1_HIT]   + l1_hit_count_i[c];
            sum_d[`ICC_SUM_L1_TRANS] = sum_d[`ICC_SUM_L1_TRANS] + l1_trans_count_i[c];
            sum_d[`ICC_SUM_L1_MISS]  = sum_d[`ICC_SUM_L1_MISS]  + l1_miss_count_i[c];
        end
        for (int b = 0; b < `ICC_NB_BANKS; b++) begin
            sum_d[`ICC_SUM_L2_HIT]   = sum_d[`ICC_SUM_L2_HIT]   + l2_hit_count_i[b];
            sum_d[`ICC_SUM_L2_TRANS] = sum_d[`ICC_SUM_L2_TRANS] + l2_trans_count_i[b];
            sum_d[`ICC_SUM_L2_MISS]  = sum_d[`ICC_SUM_L2_MISS]  + l2_miss_count_i[b];
        end
    end

    always_ff @(posedge clk_i) begin
        sum_q <= sum_d;
    end

endmodule

`default_nettype wire

//--- icc_target_seq.sv
// Target sequencer: enable and flush requests to the caches, waits for every ack
`timescale 1ns/10ps
`default_nettype none

`include "icc_macros.svh"

module icc_target_seq
    import icc_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,

    icc_seq_if.target                seq,

    output logic [`ICC_NB_CORES-1:0] l1_bypass_req_o,
    input  logic [`ICC_NB_CORES-1:0] l1_bypass_ack_i,
    output logic [`ICC_NB_CORES-1:0] l1_flush_req_o,
    input  logic [`ICC_NB_CORES-1:0] l1_flush_ack_i,

    output logic [`ICC_NB_BANKS-1:0] l2_enable_req_o,
    input  logic [`ICC_NB_BANKS-1:0] l2_enable_ack_i,
    output logic [`ICC_NB_BANKS-1:0] l2_disable_req_o,
    input  logic [`ICC_NB_BANKS-1:0] l2_disable_ack_i,
    output logic [`ICC_NB_BANKS-1:0] l2_flush_req_o,
    input  logic [`ICC_NB_BANKS-1:0] l2_flush_ack_i
);

    icc_target_word_u          enable_q;
    icc_target_word_u          flush_q;
    icc_seq_op_e               op_q;
    logic                      busy_q;     // Low in idle, high while waiting
    logic [`ICC_NB_CORES-1:0]  l1_seen_q;
    logic [`ICC_NB_BANKS-1:0]  l2_seen_q;
    logic [`ICC_NB_CORES-1:0]  l1_seen_d;
    logic [`ICC_NB_BANKS-1:0]  l2_seen_d;
    logic                      rule_met;

    // Request levels
    assign l1_bypass_req_o  = ~enable_q.bits.l1;
    assign l2_enable_req_o  =  enable_q.bits.l2;
    assign l2_disable_req_o = ~enable_q.bits.l2;
    assign l1_flush_req_o   = flush_q.bits.l1 & ~l1_seen_q;   // Dropped once acked
    assign l2_flush_req_o   = flush_q.bits.l2 & ~l2_seen_q;

    // Completion rule of the active op
    always_comb begin
        l1_seen_d = l1_seen_q;
        l2_seen_d = l2_seen_q;
        rule_met  = 1'b0;
        case (op_q)
            OP_ENABLE: begin
                l2_seen_d = l2_seen_q | l2_enable_ack_i;
                rule_met  = (&l2_seen_d) && (l1_bypass_ack_i == '0);
            end
            OP_DISABLE: begin
                l1_seen_d = l1_seen_q | l1_bypass_ack_i;
                l2_seen_d = l2_seen_q | l2_disable_ack_i;
                rule_met  = (&l1_seen_d) && (&l2_seen_d);
            end
            default: begin   // Both flush flavours
                l1_seen_d = l1_seen_q | l1_flush_ack_i;
                l2_seen_d = l2_seen_q | l2_flush_ack_i;
                rule_met  = (&l1_seen_d) && (&l2_seen_d);
            end
        endcase
    end

    assign seq.busy        = busy_q;
    assign seq.done        = busy_q & rule_met;
    assign seq.enable_word = enable_q;
    assign seq.flush_word  = flush_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q  <= '0;
            flush_q   <= '0;
            op_q      <= OP_ENABLE;
            busy_q    <= 1'b0;
            l1_seen_q <= '0;
            l2_seen_q <= '0;
        end else if (seq.start) begin
            busy_q <= 1'b1;
            op_q   <= seq.op;
            case (seq.op)
                OP_ENABLE, OP_DISABLE: begin
                    enable_q.bits.l1 <= {`ICC_NB_CORES{seq.value}};
                    enable_q.bits.l2 <= {`ICC_NB_BANKS{seq.value}};
                    l1_seen_q        <= '0;
                    l2_seen_q        <= '0;
                end
                OP_FLUSH_ALL: begin
                    flush_q.bits.l1 <= {`ICC_NB_CORES{seq.value}};
                    flush_q.bits.l2 <= {`ICC_NB_BANKS{seq.value}};
                    l1_seen_q       <= ~{`ICC_NB_CORES{seq.value}};
                    l2_seen_q       <= ~{`ICC_NB_BANKS{seq.value}};
                end
                default: begin
                    flush_q.bits.l1 <= {`ICC_NB_CORES{seq.value}};
                    flush_q.bits.l2 <= '0;
                    l1_seen_q       <= ~{`ICC_NB_CORES{seq.value}};
                    l2_seen_q       <= '1;   // Banks count as acked
                end
            endcase
        end else if (busy_q) begin
            l1_seen_q <= l1_seen_d;
            l2_seen_q <= l2_seen_d;
            if (rule_met) begin
                busy_q <= 1'b0;
                if (op_q == OP_FLUSH_ALL || op_q == OP_FLUSH_L1) begin
                    flush_q <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_icache_ctrl.sv
// Testbench of the instruction cache control unit with a cache ack responder model
`timescale 1ns/10ps
`default_nettype none

`include "icc_macros.svh"

module tb_icache_ctrl;

    localparam int C = `ICC_NB_CORES;
    localparam int B = `ICC_NB_BANKS;
    localparam int LIMIT = 200;   // Cycles per wait

    logic clk_i, rst_ni;
    logic req, wen, gnt, r_valid;
    logic [31:0] addr, wdata, r_rdata;
    logic [`ICC_ID_W-1:0] id, r_id;
    logic [C-1:0] byp_req, l1f_req, l1_clr, l1_en;
    logic [C-1:0] byp_ack = '0;
    logic [C-1:0] l1f_ack = '0;
    logic [B-1:0] l2e_req, l2d_req, l2f_req, l2_clr, l2_en;
    logic [B-1:0] l2e_ack = '0;
    logic [B-1:0] l2d_ack = '0;
    logic [B-1:0] l2f_ack = '0;
    logic [C-1:0][31:0] l1h, l1t, l1m;
    logic [B-1:0][31:0] l2h, l2t, l2m;

    logic [31:0] lcg_state = 32'h9e57_363f;
    int errors = 0;
    int checks = 0;
    int dly[5] = '{-1, -1, -1, -1, -1};
    logic [C-1:0] l1f_seen;
    logic [B-1:0] l2f_seen;
    bit in_l1_flush = 0;
    logic [`ICC_ID_W-1:0] next_id = 3;
    logic [`ICC_ID_W-1:0] exp_id_q[$];
    logic [31:0] exp_data_q[$];
    bit chk_data_q[$];
    string name_q[$];

    icache_ctrl_unit dut_i (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .speriph_req_i(req), .speriph_addr_i(addr), .speriph_wen_i(wen),
        .speriph_wdata_i(wdata), .speriph_id_i(id), .speriph_gnt_o(gnt),
        .speriph_r_valid_o(r_valid), .speriph_r_id_o(r_id), .speriph_r_rdata_o(r_rdata),
        .l1_bypass_req_o(byp_req), .l1_bypass_ack_i(byp_ack),
        .l1_flush_req_o(l1f_req), .l1_flush_ack_i(l1f_ack),
        .l2_enable_req_o(l2e_req), .l2_enable_ack_i(l2e_ack),
        .l2_disable_req_o(l2d_req), .l2_disable_ack_i(l2d_ack),
        .l2_flush_req_o(l2f_req), .l2_flush_ack_i(l2f_ack),
        .l1_hit_count_i(l1h), .l1_trans_count_i(l1t), .l1_miss_count_i(l1m),
        .l1_clear_regs_o(l1_clr), .l1_enable_regs_o(l1_en),
        .l2_hit_count_i(l2h), .l2_trans_count_i(l2t), .l2_miss_count_i(l2m),
        .l2_clear_regs_o(l2_clr), .l2_enable_regs_o(l2_en)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_delay();
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[15:8] % 6);   // 0 to 5 cycles
    endfunction

    // Expected read data from the register map rules
    function automatic logic [31:0] icc_expect(input logic [7:0] off, input bit en_bit,
                                               input bit cnt_en_bit);
        logic [31:0] s[6];
        logic [31:0] en_word;
        logic [31:0] cnt_word;
        int idx;
        s = '{default: 32'h0};
        for (int c = 0; c < C; c++) begin
            s[0] += l1h[c];
            s[1] += l1t[c];
            s[2] += l1m[c];
        end
        for (int b = 0; b < B; b++) begin
            s[3] += l2h[b];
            s[4] += l2t[b];
            s[5] += l2m[b];
        end
        en_word  = en_bit ? (32'h1 << (B + C)) - 1 : 32'h0;   // L2 and L1 fields together
        cnt_word = cnt_en_bit ? (32'h1 << (B + C)) - 1 : 32'h0;
        idx = int'(off[7:2]) - `ICC_CNT_BASE;
        if (off == `ICC_REG_ENABLE) return en_word;
        if (off == `ICC_REG_FLUSH) return 32'h0;             // Idle between flushes
        if (off == `ICC_REG_ENABLE_CNTS) return cnt_word;
        if (off[1:0] == 2'b00 && idx >= 0 && idx < 6) return s[idx];
        return `ICC_BAD_ADDR_DATA;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Verification failed");
        $finish;
    endtask

    // One access; returns on the falling edge where the response is seen
    task automatic bus_access(input string name, input bit rd, input logic [7:0] off,
                              input logic [31:0] data, input logic [31:0] exp);
        int t;
        t = 0;
        @(negedge clk_i);
        while (!gnt && t < LIMIT) begin
            @(negedge clk_i);
            t++;
        end
        if (!gnt) abort_run($sformatf("Grant never came for %s", name));
        exp_id_q.push_back(next_id);
        exp_data_q.push_back(exp);
        chk_data_q.push_back(rd);
        name_q.push_back(name);
        req = 1'b1;
        wen = rd;
        addr = {24'h0, off};
        wdata = data;
        id = next_id;
        next_id = next_id + 7;
        @(negedge clk_i);
        req = 1'b0;
        t = 0;
        while (!r_valid && t < LIMIT) begin
            @(negedge clk_i);
            t++;
        end
        if (!r_valid) abort_run($sformatf("No response for %s", name));
    endtask

    // Compare process for every response
    always @(negedge clk_i) begin
        if (rst_ni && r_valid) begin
            if (exp_id_q.size() == 0) begin
                errors++;
                $display("Response without an outstanding request");
            end else begin
                check_eq({name_q[0], " id"}, 32'(exp_id_q[0]), 32'(r_id));
                if (chk_data_q[0]) check_eq({name_q[0], " rdata"}, exp_data_q[0], r_rdata);
                void'(exp_id_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(chk_data_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    task automatic follow_level(inout logic [C-1:0] ack, input logic [C-1:0] rq, inout int d);
        if (ack != rq) begin
            if (d < 0) d = rand_delay();
            if (d == 0) begin
                ack = rq;
                d = -1;
            end else begin
                d--;
            end
        end
    endtask

    task automatic pulse_ack(output logic [C-1:0] ack, input logic [C-1:0] rq, inout int d);
        ack = '0;
        if (rq != '0) begin
            if (d < 0) d = rand_delay();
            if (d == 0) begin
                ack = rq;   // One-cycle pulse
                d = -1;
            end else begin
                d--;
            end
        end
    endtask

    // Cache responder model
    always @(negedge clk_i) begin
        logic [C-1:0] tmp;
        if (!rst_ni) begin
            byp_ack = '0;
            l2e_ack = '0;
            l2d_ack = '0;
            l1f_ack = '0;
            l2f_ack = '0;
        end else begin
            follow_level(byp_ack, byp_req, dly[0]);
            tmp = C'(l2e_ack);
            follow_level(tmp, C'(l2e_req), dly[1]);
            l2e_ack = tmp[B-1:0];
            tmp = C'(l2d_ack);
            follow_level(tmp, C'(l2d_req), dly[2]);
            l2d_ack = tmp[B-1:0];
            pulse_ack(l1f_ack, l1f_req, dly[3]);
            pulse_ack(tmp, C'(l2f_req), dly[4]);
            l2f_ack = tmp[B-1:0];
            l1f_seen |= l1f_ack;
            l2f_seen |= l2f_ack;
            if (in_l1_flush) check_eq("l1 flush l2 req", 32'h0, 32'(l2f_req));
        end
    end

    task automatic check_levels(input string name, input bit en);
        check_eq({name, " bypass"}, 32'({C{~en}}), 32'(byp_req));
        check_eq({name, " l2 enable"}, 32'({B{en}}), 32'(l2e_req));
        check_eq({name, " l2 disable"}, 32'({B{~en}}), 32'(l2d_req));
    endtask

    initial begin
        req = 1'b0;
        wen = 1'b1;
        addr = '0;
        wdata = '0;
        id = '0;
        l1f_seen = '0;
        l2f_seen = '0;
        for (int i = 0; i < C; i++) begin
            lcg_state = lcg_next(lcg_state);
            l1h[i] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            l1t[i] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            l1m[i] = lcg_state;
        end
        for (int i = 0; i < B; i++) begin
            lcg_state = lcg_next(lcg_state);
            l2h[i] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            l2t[i] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            l2m[i] = lcg_state;
        end
        rst_ni = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // Reset values
        check_levels("reset", 1'b0);
        bus_access("reset enable", 1, `ICC_REG_ENABLE, 0, icc_expect(`ICC_REG_ENABLE, 0, 0));
        bus_access("reset flush", 1, `ICC_REG_FLUSH, 0, icc_expect(`ICC_REG_FLUSH, 0, 0));
        bus_access("reset cnt en", 1, `ICC_REG_ENABLE_CNTS, 0,
                   icc_expect(`ICC_REG_ENABLE_CNTS, 0, 0));

        // Enable then disable
        for (int v = 1; v >= 0; v--) begin
            bus_access("enable write", 0, `ICC_REG_ENABLE, 32'(v), 0);
            check_levels("enable", v[0]);
            // Response only once the acks of the rule are in
            check_eq("enable bypass ack", 32'({C{~v[0]}}), 32'(byp_ack));
            check_eq("enable l2 ack", 32'({B{1'b1}}), v[0] ? 32'(l2e_ack) : 32'(l2d_ack));
            bus_access("enable read", 1, `ICC_REG_ENABLE, 0,
                       icc_expect(`ICC_REG_ENABLE, v[0], 0));
        end

        // Full flush, response only after every ack
        l1f_seen = '0;
        l2f_seen = '0;
        bus_access("flush write", 0, `ICC_REG_FLUSH, 1, 0);
        check_eq("flush l1 acks", 32'({C{1'b1}}), 32'(l1f_seen));
        check_eq("flush l2 acks", 32'({B{1'b1}}), 32'(l2f_seen));
        bus_access("flush read", 1, `ICC_REG_FLUSH, 0, icc_expect(`ICC_REG_FLUSH, 0, 0));

        // L1-only flush
        l1f_seen = '0;
        in_l1_flush = 1;
        bus_access("flush l1 write", 0, `ICC_REG_FLUSH_L1, 1, 0);
        in_l1_flush = 0;
        check_eq("flush l1 only acks", 32'({C{1'b1}}), 32'(l1f_seen));

        // Counters
        for (int k = 0; k < 6; k++) begin
            bus_access($sformatf("sum %0d", k), 1, 8'((`ICC_CNT_BASE + k) * 4), 0,
                       icc_expect(8'((`ICC_CNT_BASE + k) * 4), 0, 0));
        end
        bus_access("cnt en write", 0, `ICC_REG_ENABLE_CNTS, 1, 0);
        check_eq("l1 enable regs", 32'({C{1'b1}}), 32'(l1_en));
        check_eq("l2 enable regs", 32'({B{1'b1}}), 32'(l2_en));
        bus_access("cnt en read", 1, `ICC_REG_ENABLE_CNTS, 0,
                   icc_expect(`ICC_REG_ENABLE_CNTS, 0, 1));
        bus_access("clear write", 0, `ICC_REG_CLEAR_CNTS, 1, 0);
        check_eq("l1 clear pulse", 32'({C{1'b1}}), 32'(l1_clr));
        check_eq("l2 clear pulse", 32'({B{1'b1}}), 32'(l2_clr));
        @(negedge clk_i);
        check_eq("l1 clear end", 32'h0, 32'(l1_clr));
        check_eq("l2 clear end", 32'h0, 32'(l2_clr));
        bus_access("clear zero write", 0, `ICC_REG_CLEAR_CNTS, 0, 0);
        check_eq("l1 clear zero", 32'h0, 32'(l1_clr));

        // Unmapped offsets
        bus_access("unmapped read", 1, 8'h80, 0, icc_expect(8'h80, 0, 1));
        bus_access("unmapped write", 0, 8'h84, 1, 0);
        bus_access("flush l1 read", 1, `ICC_REG_FLUSH_L1, 0,
                   icc_expect(`ICC_REG_FLUSH_L1, 0, 1));

        repeat (2) @(negedge clk_i);
        if (exp_id_q.size() != 0) begin
            errors++;
            $display("Requests left without a response");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_icache_ctrl_assert.sv
// Protocol checks of the cache control unit: response strobe, grant and target requests
`timescale 1ns/10ps
`default_nettype none

`include "icc_macros.svh"

module tb_icache_ctrl_assert (
    input wire logic                     clk_i,
    input wire logic                     rst_ni,
    input wire logic                     req_i,
    input wire logic                     wen_i,
    input wire logic [31:0]              addr_i,
    input wire logic                     r_valid_i,
    input wire logic                     gnt_i,
    input wire logic [`ICC_NB_CORES-1:0] l1_flush_req_i,
    input wire logic [`ICC_NB_CORES-1:0] l1_flush_ack_i,
    input wire logic [`ICC_NB_BANKS-1:0] l2_flush_req_i,
    input wire logic [`ICC_NB_BANKS-1:0] l2_flush_ack_i,
    input wire logic [`ICC_NB_BANKS-1:0] l2_enable_req_i,
    input wire logic [`ICC_NB_BANKS-1:0] l2_disable_req_i
);

    logic en_wr;
    logic seq_wr;
    logic seq_wait_q;   // Sequencer write accepted, response still due

    assign en_wr  = req_i && gnt_i && !wen_i && (addr_i[7:0] == `ICC_REG_ENABLE);
    assign seq_wr = req_i && gnt_i && !wen_i &&
                    ((addr_i[7:0] == `ICC_REG_ENABLE) ||
                     (addr_i[7:0] == `ICC_REG_FLUSH) ||
                     (addr_i[7:0] == `ICC_REG_FLUSH_L1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            seq_wait_q <= 1'b0;
        end else if (seq_wr) begin
            seq_wait_q <= 1'b1;
        end else if (r_valid_i) begin
            seq_wait_q <= 1'b0;
        end
    end

    rvalid_single_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_i |=> !r_valid_i)
        else $error("r_valid high two cycles in a row");

    gnt_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        seq_wait_q && !r_valid_i |-> !gnt_i)
        else $error("gnt high while a sequencer write is outstanding");

    // A target that acked sees its request drop
    l1_flush_drop_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l1_flush_req_i & l1_flush_ack_i) != '0 |=>
            (l1_flush_req_i & $past(l1_flush_req_i & l1_flush_ack_i)) == '0)
        else $error("l1 flush request still high after its ack");

    l2_flush_drop_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l2_flush_req_i & l2_flush_ack_i) != '0 |=>
            (l2_flush_req_i & $past(l2_flush_req_i & l2_flush_ack_i)) == '0)
        else $error("l2 flush request still high after its ack");

    // L2 levels move only after an ENABLE write
    l2_level_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$stable({l2_enable_req_i, l2_disable_req_i}) |-> $past(en_wr))
        else $error("l2 enable or disable request changed without an enable write");

endmodule

bind icache_ctrl_unit tb_icache_ctrl_assert assert_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (speriph_req_i),
    .wen_i            (speriph_wen_i),
    .addr_i           (speriph_addr_i),
    .r_valid_i        (speriph_r_valid_o),
    .gnt_i            (speriph_gnt_o),
    .l1_flush_req_i   (l1_flush_req_o),
    .l1_flush_ack_i   (l1_flush_ack_i),
    .l2_flush_req_i   (l2_flush_req_o),
    .l2_flush_ack_i   (l2_flush_ack_i),
    .l2_enable_req_i  (l2_enable_req_o),
    .l2_disable_req_i (l2_disable_req_o)
);

`default_nettype wire

//--- verilog.f
+incdir+.
icc_pkg.sv
icc_ifs.sv
icc_reg_slave.sv
icc_target_seq.sv
icc_stat_unit.sv
icache_ctrl_unit.sv
tb_icache_ctrl_assert.sv
tb_icache_ctrl.sv
